// File: design/ntm_mult_pkg.sv
// Shared constants for the engine; widths above 32 bits are not supported by the APB map
`default_nettype none

package ntm_mult_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // Operand, modulus, size and APB data word
  localparam int DATA_WIDTH = 32;
  localparam int ADDR_WIDTH = 8;

  // One iteration per operand bit
  localparam int MUL_CYCLES = DATA_WIDTH;

  ////////////////////////////////////////////////////////////
  // Register map, byte offsets
  ////////////////////////////////////////////////////////////

  localparam logic [ADDR_WIDTH-1:0] REG_CTRL   = 8'h00;  // Bit 0 START, write only
  localparam logic [ADDR_WIDTH-1:0] REG_STATUS = 8'h04;  // Bit 0 BUSY, bit 1 DONE
  localparam logic [ADDR_WIDTH-1:0] REG_MODULO = 8'h08;
  localparam logic [ADDR_WIDTH-1:0] REG_SIZE_I = 8'h0C;
  localparam logic [ADDR_WIDTH-1:0] REG_SIZE_J = 8'h10;
  localparam logic [ADDR_WIDTH-1:0] REG_LENGTH = 8'h14;
  localparam logic [ADDR_WIDTH-1:0] REG_COUNT  = 8'h18;  // Read only

  ////////////////////////////////////////////////////////////
  // Controller states
  ////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    IDLE     = 3'd0,  // No job
    LOAD     = 3'd1,  // First word of an element
    OPERAND  = 3'd2,  // Further words
    MULTIPLY = 3'd3,  // Multiplier running
    EMIT     = 3'd4   // Output pulse
  } ctrl_state_e;

endpackage

`default_nettype wire

// File: design/ntm_apb_regs.sv
// APB slave with zero wait states; configuration writes are refused while a job runs
`default_nettype none

module ntm_apb_regs (
  input  wire                               CLK,
  input  wire                               RST,
  input  wire                               PSEL,
  input  wire                               PENABLE,
  input  wire                               PWRITE,
  input  wire [ntm_mult_pkg::ADDR_WIDTH-1:0] PADDR,
  input  wire [ntm_mult_pkg::DATA_WIDTH-1:0] PWDATA,
  output logic [ntm_mult_pkg::DATA_WIDTH-1:0] PRDATA,
  output logic                              PREADY,
  output logic                              PSLVERR,
  input  wire                               busy,
  input  wire                               job_done,
  input  wire                               out_valid,
  output logic                              start,
  output logic [ntm_mult_pkg::DATA_WIDTH-1:0] modulo,
  output logic [ntm_mult_pkg::DATA_WIDTH-1:0] size_i,
  output logic [ntm_mult_pkg::DATA_WIDTH-1:0] size_j,
  output logic [ntm_mult_pkg::DATA_WIDTH-1:0] length,
  output logic                              irq
);

  import ntm_mult_pkg::*;

  logic                  access;
  logic                  mapped;
  logic                  is_cfg;
  logic                  wr_ok;
  logic                  done;
  logic [DATA_WIDTH-1:0] count;

  ////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////

  // Second cycle of a transfer
  assign access = PSEL && PENABLE;

  always_comb begin
    is_cfg = (PADDR == REG_MODULO) || (PADDR == REG_SIZE_I) ||
             (PADDR == REG_SIZE_J) || (PADDR == REG_LENGTH);
    mapped = is_cfg || (PADDR == REG_CTRL) || (PADDR == REG_STATUS) ||
             (PADDR == REG_COUNT);
  end

  // Never any wait state
  assign PREADY = 1'b1;

  // Unmapped, busy config write, or CTRL read
  assign PSLVERR = access && (!mapped || (PWRITE && is_cfg && busy) ||
                              (!PWRITE && (PADDR == REG_CTRL)));

  // Faulting writes have no effect
  assign wr_ok = access && PWRITE && !PSLVERR;

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      start  <= 1'b0;
      done   <= 1'b0;
      count  <= '0;
      modulo <= '0;
      size_i <= '0;
      size_j <= '0;
      length <= '0;
    end else begin
      // One-cycle pulse, dropped while a job runs
      start <= wr_ok && (PADDR == REG_CTRL) && PWDATA[0] && !busy && !start;
      if (wr_ok) begin
        case (PADDR)
          REG_MODULO: modulo <= PWDATA;
          REG_SIZE_I: size_i <= PWDATA;
          REG_SIZE_J: size_j <= PWDATA;
          REG_LENGTH: length <= PWDATA;
          default: ;
        endcase
      end
      // Sticky DONE, cleared by the next job
      if (start) begin
        done  <= 1'b0;
        count <= '0;
      end else begin
        if (job_done)
          done <= 1'b1;
        if (out_valid)
          count <= count + 1'b1;
      end
    end
  end

  assign irq = done;

  // Read mux, sampled by the master in the access phase
  always_comb begin
    case (PADDR)
      REG_STATUS: PRDATA = {{(DATA_WIDTH-2){1'b0}}, done, busy};
      REG_MODULO: PRDATA = modulo;
      REG_SIZE_I: PRDATA = size_i;
      REG_SIZE_J: PRDATA = size_j;
      REG_LENGTH: PRDATA = length;
      REG_COUNT:  PRDATA = count;
      default:    PRDATA = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // Error response only in the access phase that follows a setup phase
  a_slverr_access: assert property (@(posedge CLK) disable iff (RST)
    PSLVERR |-> (PSEL && PENABLE && $past(PSEL && !PENABLE)))
    else $error("PSLVERR outside access phase");

endmodule

`default_nettype wire

// File: design/ntm_index_counter.sv
// Word, column and row counters; sizes must be at least 1 and stay fixed during a job
`default_nettype none

module ntm_index_counter (
  input  wire                                CLK,
  input  wire                                RST,
  input  wire                                job_start,
  input  wire                                word_step,
  input  wire [ntm_mult_pkg::DATA_WIDTH-1:0] size_i,
  input  wire [ntm_mult_pkg::DATA_WIDTH-1:0] size_j,
  input  wire [ntm_mult_pkg::DATA_WIDTH-1:0] length,
  output logic                               first_word,
  output logic                               last_word,
  output logic                               last_col,
  output logic                               last_row
);

  import ntm_mult_pkg::*;

  logic [DATA_WIDTH-1:0] word_idx;
  logic [DATA_WIDTH-1:0] col_idx;
  logic [DATA_WIDTH-1:0] row_idx;

  // Position flags for the current word
  assign first_word = (word_idx == '0);
  assign last_word  = (word_idx == length - 1'b1);
  assign last_col   = (col_idx == size_j - 1'b1);
  assign last_row   = (row_idx == size_i - 1'b1);

  ////////////////////////////////////////////////////////////
  // Nested counting, word innermost
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      word_idx <= '0;
      col_idx  <= '0;
      row_idx  <= '0;
    end else if (job_start) begin
      word_idx <= '0;
      col_idx  <= '0;
      row_idx  <= '0;
    end else if (word_step) begin
      if (!last_word) begin
        word_idx <= word_idx + 1'b1;
      end else begin
        // Element finished, carry into column
        word_idx <= '0;
        if (!last_col) begin
          col_idx <= col_idx + 1'b1;
        end else begin
          // Row finished; wraps after the final row
          col_idx <= '0;
          row_idx <= last_row ? '0 : row_idx + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: design/ntm_mod_multiplier.sv
// Interleaved modular multiply; operands must be below a modulus of at most 2^31-1
`default_nettype none

module ntm_mod_multiplier (
  input  wire                                 CLK,
  input  wire                                 RST,
  input  wire                                 mul_start,
  input  wire  [ntm_mult_pkg::DATA_WIDTH-1:0] mul_a,
  input  wire  [ntm_mult_pkg::DATA_WIDTH-1:0] mul_b,
  input  wire  [ntm_mult_pkg::DATA_WIDTH-1:0] modulo,
  output logic                                mul_done,
  output logic [ntm_mult_pkg::DATA_WIDTH-1:0] mul_result
);

  import ntm_mult_pkg::*;

  localparam int CW = $clog2(MUL_CYCLES + 1);

  logic [CW-1:0]         cnt;
  logic [DATA_WIDTH-1:0] a_sh;
  logic [DATA_WIDTH-1:0] b_reg;
  logic [DATA_WIDTH-1:0] part;
  logic [DATA_WIDTH:0]   mod_x;
  logic [DATA_WIDTH:0]   dbl;
  logic [DATA_WIDTH:0]   dbl_red;
  logic [DATA_WIDTH:0]   sum;
  logic [DATA_WIDTH:0]   sum_red;

  ////////////////////////////////////////////////////////////
  // One step: double, add, reduce
  ////////////////////////////////////////////////////////////

  // One spare bit keeps 2p and p+b exact
  assign mod_x = {1'b0, modulo};

  always_comb begin
    dbl     = {part, 1'b0};
    dbl_red = (dbl >= mod_x) ? dbl - mod_x : dbl;
    // Add b when the current bit of a is set
    sum     = dbl_red + (a_sh[DATA_WIDTH-1] ? {1'b0, b_reg} : '0);
    sum_red = (sum >= mod_x) ? sum - mod_x : sum;
  end

  ////////////////////////////////////////////////////////////
  // Iteration control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      cnt      <= '0;
      mul_done <= 1'b0;
    end else begin
      // Last step completes in the cycle before done
      mul_done <= (cnt == CW'(1));
      if (mul_start)
        cnt <= CW'(MUL_CYCLES);
      else if (cnt != '0)
        cnt <= cnt - 1'b1;
    end
  end

  // Operands and partial product
  always_ff @(posedge CLK) begin
    if (mul_start) begin
      a_sh  <= mul_a;
      b_reg <= mul_b;
      part  <= '0;
    end else if (cnt != '0) begin
      // MSB first
      a_sh <= {a_sh[DATA_WIDTH-2:0], 1'b0};
      part <= sum_red[DATA_WIDTH-1:0];
    end
  end

  assign mul_result = part;

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // Reduction relies on both inputs being residues
  a_operands_reduced: assert property (@(posedge CLK) disable iff (RST)
    mul_start |-> (mul_a < modulo) && (mul_b < modulo))
    else $error("Multiplier operand not below modulus");

  a_no_restart: assert property (@(posedge CLK) disable iff (RST)
    mul_start |-> (cnt == '0))
    else $error("mul_start while multiplier busy");

endmodule

`default_nettype wire

// File: design/ntm_mult_ctrl.sv
// Job sequencer; the output has no back-pressure and must be taken when out_valid pulses
`default_nettype none

module ntm_mult_ctrl (
  input  wire                                 CLK,
  input  wire                                 RST,
  input  wire                                 start,
  output logic                                busy,
  output logic                                job_done,
  input  wire                                 in_valid,
  input  wire  [ntm_mult_pkg::DATA_WIDTH-1:0] in_data,
  output logic                                in_ready,
  input  wire                                 first_word,
  input  wire                                 last_word,
  input  wire                                 last_col,
  input  wire                                 last_row,
  output logic                                job_start,
  output logic                                word_step,
  output logic                                mul_start,
  output logic [ntm_mult_pkg::DATA_WIDTH-1:0] mul_a,
  output logic [ntm_mult_pkg::DATA_WIDTH-1:0] mul_b,
  input  wire                                 mul_done,
  input  wire  [ntm_mult_pkg::DATA_WIDTH-1:0] mul_result,
  output logic                                out_valid,
  output logic                                out_row_end,
  output logic                                out_last,
  output logic [ntm_mult_pkg::DATA_WIDTH-1:0] out_data
);

  import ntm_mult_pkg::*;

  ctrl_state_e           state;
  logic                  xfer;
  logic [DATA_WIDTH-1:0] acc;
  logic [DATA_WIDTH-1:0] opnd;

  ////////////////////////////////////////////////////////////
  // Handshake and counter control
  ////////////////////////////////////////////////////////////

  assign in_ready  = (state == LOAD) || (state == OPERAND);
  assign xfer      = in_valid && in_ready;
  assign busy      = (state != IDLE);
  assign job_start = start && (state == IDLE);

  // Index stays on the word until it has been consumed;
  // the final word of an element is stepped past in EMIT
  assign word_step = (xfer && first_word && !last_word) ||
                     ((state == MULTIPLY) && mul_done && !last_word) ||
                     (state == EMIT);

  // Element output straight from the accumulator
  assign out_valid   = (state == EMIT);
  assign out_row_end = out_valid && last_col;
  assign out_last    = out_valid && last_col && last_row;
  assign out_data    = acc;
  assign job_done    = out_last;

  // Running product times new word
  assign mul_a = acc;
  assign mul_b = opnd;

  ////////////////////////////////////////////////////////////
  // State machine
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= IDLE;
      mul_start <= 1'b0;
    end else begin
      // Issued the cycle after a non-first transfer
      mul_start <= xfer && !first_word;
      case (state)
        IDLE: begin
          if (start)
            state <= LOAD;
        end
        LOAD, OPERAND: begin
          // Stall here while the host has nothing
          if (xfer) begin
            if (!first_word)
              state <= MULTIPLY;
            else if (last_word)
              state <= EMIT;
            else
              state <= OPERAND;
          end
        end
        MULTIPLY: begin
          if (mul_done)
            state <= last_word ? EMIT : OPERAND;
        end
        EMIT: begin
          // Single cycle
          state <= (last_col && last_row) ? IDLE : LOAD;
        end
        default: state <= IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (xfer && first_word)
      acc <= in_data;
    else if ((state == MULTIPLY) && mul_done)
      acc <= mul_result;
    // Word held for the multiplier
    if (xfer && !first_word)
      opnd <= in_data;
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // An element only follows cycles of a job already under way
  a_out_in_job: assert property (@(posedge CLK) disable iff (RST)
    out_valid |-> (busy && $past(busy)))
    else $error("out_valid outside a job");

  // Input closed from a multiplied word until the product returns
  a_no_ready_mul: assert property (@(posedge CLK) disable iff (RST)
    (xfer && !first_word) |=> (!in_ready throughout (mul_done [->1])))
    else $error("in_ready during multiply");

endmodule

`default_nettype wire

// File: design/ntm_mult_top.sv
// Engine top level; the output receiver must accept every out_valid pulse
`default_nettype none

module ntm_mult_top (
  input  wire                                 CLK,
  input  wire                                 RST,
  input  wire                                 PSEL,
  input  wire                                 PENABLE,
  input  wire                                 PWRITE,
  input  wire  [ntm_mult_pkg::ADDR_WIDTH-1:0] PADDR,
  input  wire  [ntm_mult_pkg::DATA_WIDTH-1:0] PWDATA,
  output logic [ntm_mult_pkg::DATA_WIDTH-1:0] PRDATA,
  output logic                                PREADY,
  output logic                                PSLVERR,
  input  wire                                 in_valid,
  input  wire  [ntm_mult_pkg::DATA_WIDTH-1:0] in_data,
  output logic                                in_ready,
  output logic                                out_valid,
  output logic [ntm_mult_pkg::DATA_WIDTH-1:0] out_data,
  output logic                                out_row_end,
  output logic                                out_last,
  output logic                                irq
);

  import ntm_mult_pkg::*;

  // Register file and controller
  logic                  start;
  logic                  busy;
  logic                  job_done;
  logic [DATA_WIDTH-1:0] modulo;
  logic [DATA_WIDTH-1:0] size_i;
  logic [DATA_WIDTH-1:0] size_j;
  logic [DATA_WIDTH-1:0] length;

  // Index counter
  logic job_start;
  logic word_step;
  logic first_word;
  logic last_word;
  logic last_col;
  logic last_row;

  // Multiplier
  logic                  mul_start;
  logic                  mul_done;
  logic [DATA_WIDTH-1:0] mul_a;
  logic [DATA_WIDTH-1:0] mul_b;
  logic [DATA_WIDTH-1:0] mul_result;

  ntm_apb_regs i_regs (
    .CLK(CLK), .RST(RST),
    .PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE), .PADDR(PADDR),
    .PWDATA(PWDATA), .PRDATA(PRDATA), .PREADY(PREADY), .PSLVERR(PSLVERR),
    .busy(busy), .job_done(job_done), .out_valid(out_valid), .start(start),
    .modulo(modulo), .size_i(size_i), .size_j(size_j), .length(length),
    .irq(irq)
  );

  ntm_mult_ctrl i_ctrl (
    .CLK(CLK), .RST(RST),
    .start(start), .busy(busy), .job_done(job_done),
    .in_valid(in_valid), .in_data(in_data), .in_ready(in_ready),
    .first_word(first_word), .last_word(last_word),
    .last_col(last_col), .last_row(last_row),
    .job_start(job_start), .word_step(word_step),
    .mul_start(mul_start), .mul_a(mul_a), .mul_b(mul_b),
    .mul_done(mul_done), .mul_result(mul_result),
    .out_valid(out_valid), .out_row_end(out_row_end),
    .out_last(out_last), .out_data(out_data)
  );

  ntm_index_counter i_index (
    .CLK(CLK), .RST(RST),
    .job_start(job_start), .word_step(word_step),
    .size_i(size_i), .size_j(size_j), .length(length),
    .first_word(first_word), .last_word(last_word),
    .last_col(last_col), .last_row(last_row)
  );

  ntm_mod_multiplier i_mul (
    .CLK(CLK), .RST(RST),
    .mul_start(mul_start), .mul_a(mul_a), .mul_b(mul_b), .modulo(modulo),
    .mul_done(mul_done), .mul_result(mul_result)
  );

endmodule

`default_nettype wire

// File: tests/ntm_mult_tb.sv
// Engine testbench on a fixed seed; the output is taken every cycle and jobs stay under 1000 cycles
`default_nettype none

module ntm_mult_tb;

  import ntm_mult_pkg::*;

  // Cycles allowed for any single wait
  localparam int WAIT_LIMIT = 1000;

  logic                  CLK;
  logic                  RST;
  logic                  PSEL;
  logic                  PENABLE;
  logic                  PWRITE;
  logic [ADDR_WIDTH-1:0] PADDR;
  logic [DATA_WIDTH-1:0] PWDATA;
  logic [DATA_WIDTH-1:0] PRDATA;
  logic                  PREADY;
  logic                  PSLVERR;
  logic                  in_valid;
  logic [DATA_WIDTH-1:0] in_data;
  logic                  in_ready;
  logic                  out_valid;
  logic [DATA_WIDTH-1:0] out_data;
  logic                  out_row_end;
  logic                  out_last;
  logic                  irq;

  integer seed;

  // Word on the bus opens an element
  logic drive_first;

  // Expected elements as {last, row_end, data}
  logic [DATA_WIDTH+1:0] exp_q [$];
  logic                  exp_avail;
  logic [DATA_WIDTH-1:0] exp_data;
  logic                  exp_row_end;
  logic                  exp_last;

  ntm_mult_top i_dut (
    .CLK(CLK), .RST(RST),
    .PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE), .PADDR(PADDR),
    .PWDATA(PWDATA), .PRDATA(PRDATA), .PREADY(PREADY), .PSLVERR(PSLVERR),
    .in_valid(in_valid), .in_data(in_data), .in_ready(in_ready),
    .out_valid(out_valid), .out_data(out_data),
    .out_row_end(out_row_end), .out_last(out_last), .irq(irq)
  );

  always #2 CLK = ~CLK;

  ////////////////////////////////////////////////////////////
  // Failure reporting and expected-element queue
  ////////////////////////////////////////////////////////////

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Stopped at first failure");
  endtask

  task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] actual,
                             input logic [DATA_WIDTH-1:0] expected);
    assert (actual === expected)
      else stop_with_failure($sformatf("Error: %s expected %h actual %h",
                                       name, expected, actual));
  endtask

  task automatic update_head();
    exp_avail = (exp_q.size() != 0);
    if (exp_avail)
      {exp_last, exp_row_end, exp_data} = exp_q[0];
  endtask

  task automatic push_expected(input logic [DATA_WIDTH-1:0] data, input logic row_end,
                               input logic last);
    exp_q.push_back({last, row_end, data});
    update_head();
  endtask

  // Head retires with each output pulse
  always @(posedge CLK) begin
    if (out_valid && exp_q.size() != 0) begin
      void'(exp_q.pop_front());
      update_head();
    end
  end

  ////////////////////////////////////////////////////////////
  // Output and handshake checks
  ////////////////////////////////////////////////////////////

  a_out_expected: assert property (@(posedge CLK) disable iff (RST)
    out_valid |-> exp_avail)
    else stop_with_failure("Output element arrived with none expected");

  a_out_data: assert property (@(posedge CLK) disable iff (RST)
    (out_valid && exp_avail) |-> (out_data == exp_data))
    else stop_with_failure($sformatf("Error: out_data expected %h actual %h",
                                     $sampled(exp_data), $sampled(out_data)));

  a_out_row_end: assert property (@(posedge CLK) disable iff (RST)
    (out_valid && exp_avail) |-> (out_row_end == exp_row_end))
    else stop_with_failure($sformatf("Error: out_row_end expected %h actual %h",
                                     $sampled(exp_row_end), $sampled(out_row_end)));

  a_out_last: assert property (@(posedge CLK) disable iff (RST)
    (out_valid && exp_avail) |-> (out_last == exp_last))
    else stop_with_failure($sformatf("Error: out_last expected %h actual %h",
                                     $sampled(exp_last), $sampled(out_last)));

  // Flags only travel with a result
  a_flags_with_valid: assert property (@(posedge CLK) disable iff (RST)
    (out_row_end || out_last) |-> out_valid)
    else stop_with_failure("Output flag raised without out_valid");

  // Multiply start, MUL_CYCLES+1 cycles to done, then the state change
  a_ready_after_operand: assert property (@(posedge CLK) disable iff (RST)
    (in_valid && in_ready && !drive_first) |=> !in_ready [*(MUL_CYCLES + 2)])
    else stop_with_failure("in_ready rose while a product was still being formed");

  a_no_ready_on_emit: assert property (@(posedge CLK) disable iff (RST)
    out_valid |-> !in_ready)
    else stop_with_failure("in_ready high while an output was presented");

  ////////////////////////////////////////////////////////////
  // APB and stream drivers, all entered on a falling edge
  ////////////////////////////////////////////////////////////

  task automatic apb_transfer(input logic write, input logic [ADDR_WIDTH-1:0] addr,
                              input logic [DATA_WIDTH-1:0] wdata,
                              output logic [DATA_WIDTH-1:0] rdata, output logic err);
    int   n;
    logic ready;
    // Setup phase
    PSEL    = 1'b1;
    PENABLE = 1'b0;
    PWRITE  = write;
    PADDR   = addr;
    PWDATA  = wdata;
    @(negedge CLK);
    PENABLE = 1'b1;
    ready   = 1'b0;
    n       = 0;
    while (!ready && n < WAIT_LIMIT) begin
      @(posedge CLK);
      ready = PREADY;
      rdata = PRDATA;
      err   = PSLVERR;
      n++;
    end
    @(negedge CLK);
    PSEL    = 1'b0;
    PENABLE = 1'b0;
    PWRITE  = 1'b0;
    if (!ready)
      stop_with_failure("APB access got no PREADY before the timeout");
  endtask

  task automatic apb_write(input logic [ADDR_WIDTH-1:0] addr,
                           input logic [DATA_WIDTH-1:0] data, output logic err);
    logic [DATA_WIDTH-1:0] unused;
    apb_transfer(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input logic [ADDR_WIDTH-1:0] addr,
                          output logic [DATA_WIDTH-1:0] data, output logic err);
    apb_transfer(1'b0, addr, '0, data, err);
  endtask

  // Random idle gap, then hold the word until it transfers
  task automatic send_word(input logic [DATA_WIDTH-1:0] word, input logic first);
    int   gap;
    int   n;
    logic taken;
    gap = $unsigned($random(seed)) % 4;
    repeat (gap) @(negedge CLK);
    in_valid    = 1'b1;
    in_data     = word;
    drive_first = first;
    taken       = 1'b0;
    n           = 0;
    while (!taken && n < WAIT_LIMIT) begin
      @(posedge CLK);
      taken = in_ready;
      n++;
    end
    @(negedge CLK);
    in_valid = 1'b0;
    if (!taken)
      stop_with_failure("Stream word was not accepted before the timeout");
  endtask

  task automatic wait_for_irq();
    int   n;
    logic seen;
    seen = 1'b0;
    n    = 0;
    while (!seen && n < WAIT_LIMIT) begin
      @(posedge CLK);
      seen = irq;
      n++;
    end
    @(negedge CLK);
    if (!seen)
      stop_with_failure("Job did not raise irq before the timeout");
  endtask

  ////////////////////////////////////////////////////////////
  // One complete job against the reference model
  ////////////////////////////////////////////////////////////

  task automatic run_job(input int si, input int sj, input int len, input logic bad_access);
    logic [DATA_WIDTH-1:0] m;
    logic [DATA_WIDTH-1:0] word;
    logic [DATA_WIDTH-1:0] rdata;
    logic [63:0]           prod;
    logic                  err;
    int                    e;
    int                    w;
    // Modulus in 2 .. 2^31-1
    m = $unsigned($random(seed)) & 32'h7FFF_FFFF;
    if (m < 2)
      m = 2;
    apb_write(REG_MODULO, m, err);
    check_value("PSLVERR", err, 0);
    apb_write(REG_SIZE_I, si, err);
    check_value("PSLVERR", err, 0);
    apb_write(REG_SIZE_J, sj, err);
    check_value("PSLVERR", err, 0);
    apb_write(REG_LENGTH, len, err);
    check_value("PSLVERR", err, 0);
    apb_write(REG_CTRL, 32'h1, err);
    // START clears DONE and COUNT of the previous job
    apb_read(REG_STATUS, rdata, err);
    check_value("STATUS", rdata, 32'h1);
    apb_read(REG_COUNT, rdata, err);
    check_value("COUNT", rdata, 0);
    if (bad_access) begin
      // Configuration is locked while busy
      apb_write(REG_MODULO, m ^ 32'h1, err);
      check_value("PSLVERR", err, 1);
      apb_read(REG_MODULO, rdata, err);
      check_value("PSLVERR", err, 0);
      check_value("MODULO", rdata, m);
      apb_read(8'h40, rdata, err);
      check_value("PSLVERR", err, 1);
      apb_read(REG_CTRL, rdata, err);
      check_value("PSLVERR", err, 1);
    end
    // Elements in row order, running product per element
    for (e = 0; e < si * sj; e++) begin
      for (w = 0; w < len; w++) begin
        word = $unsigned($random(seed)) % m;
        if (w == 0)
          prod = {32'b0, word};
        else
          prod = (prod * {32'b0, word}) % {32'b0, m};
        if (w == len - 1)
          push_expected(prod[DATA_WIDTH-1:0], (e % sj) == sj - 1, e == si * sj - 1);
        send_word(word, w == 0);
      end
    end
    wait_for_irq();
    check_value("expected elements left", exp_q.size(), 0);
    apb_read(REG_STATUS, rdata, err);
    check_value("STATUS", rdata, 32'h2);
    apb_read(REG_COUNT, rdata, err);
    check_value("COUNT", rdata, si * sj);
    check_value("irq", irq, 1);
  endtask

  ////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic [DATA_WIDTH-1:0] rdata;
    logic                  err;
    seed        = 50;
    CLK         = 1'b0;
    RST         = 1'b1;
    PSEL        = 1'b0;
    PENABLE     = 1'b0;
    PWRITE      = 1'b0;
    PADDR       = '0;
    PWDATA      = '0;
    in_valid    = 1'b0;
    in_data     = '0;
    drive_first = 1'b0;
    exp_avail   = 1'b0;
    exp_data    = '0;
    exp_row_end = 1'b0;
    exp_last    = 1'b0;
    repeat (8) @(negedge CLK);
    RST = 1'b0;

    // Idle after reset
    check_value("irq", irq, 0);
    check_value("in_ready", in_ready, 0);
    check_value("out_valid", out_valid, 0);
    check_value("PSLVERR", PSLVERR, 0);
    apb_read(REG_STATUS, rdata, err);
    check_value("STATUS", rdata, 0);
    apb_read(REG_COUNT, rdata, err);
    check_value("COUNT", rdata, 0);

    // Single word passes straight through
    run_job(1, 1, 1, 1'b0);
    // Full matrix with locked-register accesses mid job
    run_job(2, 3, 4, 1'b1);
    // Different shape, rows of two
    run_job(3, 2, 3, 1'b0);

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
design/ntm_mult_pkg.sv
design/ntm_apb_regs.sv
design/ntm_index_counter.sv
design/ntm_mod_multiplier.sv
design/ntm_mult_ctrl.sv
design/ntm_mult_top.sv
tests/ntm_mult_tb.sv
